// File: src/mouseDefs.sv
`default_nettype none

package mouseDefs;

  ////////////////////////////////////////////////////////////
  // Data types shared by the host blocks
  ////////////////////////////////////////////////////////////

  // One byte on the PS/2 wire
  typedef logic [7:0] byte_t;

  // Receiver error code, zero for a clean byte
  typedef logic [1:0] errCode_t;

  localparam errCode_t ERR_NONE = 2'b00;

  ////////////////////////////////////////////////////////////
  // Host to mouse command bytes
  ////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    cmdReset        = 8'hFF,
    cmdEnableReport = 8'hF4,
    cmdSetRate      = 8'hF3,
    cmdGetId        = 8'hF2,
    // Sample rate arguments used by the wheel knock
    rate200         = 8'hC8,
    rate100         = 8'h64,
    rate80          = 8'h50
  } hostCmd_t;

  // Replies from the mouse
  localparam byte_t REPLY_ACK            = 8'hFA;
  localparam byte_t REPLY_SELF_TEST_PASS = 8'hAA;
  localparam byte_t ID_STANDARD          = 8'h00;
  localparam byte_t ID_WHEEL             = 8'h03;

  ////////////////////////////////////////////////////////////
  // FSM state encodings
  ////////////////////////////////////////////////////////////

  // Byte exchange engine
  typedef enum logic [2:0] {
    idle,
    sendPulse,
    waitSent,
    waitAck,
    waitByte
  } linkState_t;

  // Init sequencer phases
  typedef enum logic [3:0] {
    powerUp,
    issue,
    waitLink,
    stream
  } seqState_t;

endpackage

`default_nettype wire

// File: src/hostLink.sv
`timescale 1ns/1ps
`default_nettype none

// Sends one command and checks its acknowledge, or receives one byte
module hostLink (
  input  wire logic              CLK,
  input  wire logic              RESET,
  input  wire logic              cmdStart,
  input  wire logic              readStart,
  input  wire logic              BYTE_SENT,
  input  wire logic              BYTE_READY,
  input  wire mouseDefs::byte_t    cmdByte,
  input  wire mouseDefs::byte_t    BYTE_READ,
  input  wire mouseDefs::errCode_t BYTE_ERROR_CODE,
  output logic                   SEND_BYTE,
  output logic                   READ_ENABLE,
  output logic                   linkBusy,
  output logic                   linkDone,
  output logic                   linkFail,
  output mouseDefs::byte_t         BYTE_TO_SEND,
  output mouseDefs::byte_t         rxByte
);

  mouseDefs::linkState_t state;
  logic                  byteClean;

  // Receiver reported no framing or parity problem
  assign byteClean = (BYTE_ERROR_CODE == mouseDefs::ERR_NONE);

  // Transmitter strobe lasts the single sendPulse cycle
  assign SEND_BYTE   = (state == mouseDefs::sendPulse);
  // Receiver stays enabled for the whole wait
  assign READ_ENABLE = (state == mouseDefs::waitAck) || (state == mouseDefs::waitByte);
  assign linkBusy    = (state != mouseDefs::idle);

  ////////////////////////////////////////////////////////////
  // Exchange FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state    <= mouseDefs::idle;
      linkDone <= 1'b0;
      linkFail <= 1'b0;
    end else begin
      // Result strobes are single cycle
      linkDone <= 1'b0;
      linkFail <= 1'b0;
      case (state)
        mouseDefs::idle: begin
          // Command wins if both arrive
          if (cmdStart) begin
            state <= mouseDefs::sendPulse;
          end else if (readStart) begin
            state <= mouseDefs::waitByte;
          end
        end
        mouseDefs::sendPulse: state <= mouseDefs::waitSent;
        mouseDefs::waitSent: begin
          if (BYTE_SENT) begin
            state <= mouseDefs::waitAck;
          end
        end
        mouseDefs::waitAck: begin
          // Only a clean FA counts as acknowledge
          if (BYTE_READY) begin
            state <= mouseDefs::idle;
            if (byteClean && (BYTE_READ == mouseDefs::REPLY_ACK)) begin
              linkDone <= 1'b1;
            end else begin
              linkFail <= 1'b1;
            end
          end
        end
        mouseDefs::waitByte: begin
          // Content is judged upstream
          if (BYTE_READY) begin
            state    <= mouseDefs::idle;
            linkDone <= byteClean;
            linkFail <= !byteClean;
          end
        end
        default: state <= mouseDefs::idle;
      endcase
    end
  end

  // Latched command byte and received byte
  always_ff @(posedge CLK) begin
    if ((state == mouseDefs::idle) && cmdStart) begin
      BYTE_TO_SEND <= cmdByte;
    end
    if (READ_ENABLE && BYTE_READY) begin
      rxByte <= BYTE_READ;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  sendSingle: assert property (@(posedge CLK) disable iff (RESET)
    SEND_BYTE |=> !SEND_BYTE)
    else $error("SEND_BYTE held for two cycles");

  sendReadExcl: assert property (@(posedge CLK) disable iff (RESET)
    !(SEND_BYTE && READ_ENABLE))
    else $error("SEND_BYTE and READ_ENABLE high together");

endmodule

`default_nettype wire

// File: src/mouseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Power-up wait, init script with ID check, then streaming reads
module mouseSequencer #(
  parameter int POWER_UP_CYCLES = 1_000_000
) (
  input  wire logic           CLK,
  input  wire logic           RESET,
  input  wire logic           linkBusy,
  input  wire logic           linkDone,
  input  wire logic           linkFail,
  input  wire mouseDefs::byte_t rxByte,
  output logic                cmdStart,
  output logic                readStart,
  output logic                streaming,
  output logic                streamValid,
  output logic                wheelMode,
  output mouseDefs::byte_t      cmdByte,
  output mouseDefs::byte_t      streamByte
);

  // Counter wide enough to reach the full delay
  localparam int CNT_W = $clog2(POWER_UP_CYCLES + 1);
  // Final script step reads the device ID
  localparam logic [3:0] ID_STEP = 4'd11;

  mouseDefs::seqState_t state;
  logic [CNT_W-1:0]     powerCount;
  logic [3:0]           stepIdx;

  // Decoded script entry
  mouseDefs::hostCmd_t stepCmd;
  logic                stepIsRead;
  mouseDefs::byte_t    stepExpect;

  ////////////////////////////////////////////////////////////
  // Init script
  ////////////////////////////////////////////////////////////

  always_comb begin
    stepCmd    = mouseDefs::cmdReset;
    stepIsRead = 1'b0;
    stepExpect = mouseDefs::REPLY_ACK;
    case (stepIdx)
      4'd0: stepCmd = mouseDefs::cmdReset;
      // Self-test result then standard ID follow the reset ack
      4'd1: begin
        stepIsRead = 1'b1;
        stepExpect = mouseDefs::REPLY_SELF_TEST_PASS;
      end
      4'd2: begin
        stepIsRead = 1'b1;
        stepExpect = mouseDefs::ID_STANDARD;
      end
      4'd3: stepCmd = mouseDefs::cmdEnableReport;
      // Wheel knock 200 100 80
      4'd4: stepCmd = mouseDefs::cmdSetRate;
      4'd5: stepCmd = mouseDefs::rate200;
      4'd6: stepCmd = mouseDefs::cmdSetRate;
      4'd7: stepCmd = mouseDefs::rate100;
      4'd8: stepCmd = mouseDefs::cmdSetRate;
      4'd9: stepCmd = mouseDefs::rate80;
      4'd10: stepCmd = mouseDefs::cmdGetId;
      // ID reply is 03 or 00, decided in the FSM
      4'd11: begin
        stepIsRead = 1'b1;
        stepExpect = mouseDefs::ID_WHEEL;
      end
      default: stepCmd = mouseDefs::cmdReset;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state      <= mouseDefs::powerUp;
      powerCount <= '0;
      stepIdx    <= '0;
      wheelMode  <= 1'b0;
    end else begin
      case (state)
        mouseDefs::powerUp: begin
          // Script restarts from the reset command
          if (powerCount == CNT_W'(POWER_UP_CYCLES)) begin
            state      <= mouseDefs::issue;
            powerCount <= '0;
            stepIdx    <= '0;
          end else begin
            powerCount <= powerCount + 1'b1;
          end
        end
        mouseDefs::issue: begin
          if (!linkBusy) begin
            state <= mouseDefs::waitLink;
          end
        end
        mouseDefs::waitLink: begin
          if (linkFail) begin
            state <= mouseDefs::powerUp;
          end else if (linkDone) begin
            if (stepIdx == ID_STEP) begin
              // Any other ID is treated as a broken init
              if ((rxByte == mouseDefs::ID_WHEEL) || (rxByte == mouseDefs::ID_STANDARD)) begin
                wheelMode <= (rxByte == stepExpect);
                state     <= mouseDefs::stream;
              end else begin
                state <= mouseDefs::powerUp;
              end
            end else if (stepIsRead && (rxByte != stepExpect)) begin
              state <= mouseDefs::powerUp;
            end else begin
              stepIdx <= stepIdx + 1'b1;
              state   <= mouseDefs::issue;
            end
          end
        end
        mouseDefs::stream: begin
          // Bad byte mid-stream reinitialises the mouse
          if (linkFail) begin
            state <= mouseDefs::powerUp;
          end
        end
        default: state <= mouseDefs::powerUp;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Link requests and stream output
  ////////////////////////////////////////////////////////////

  assign cmdByte   = stepCmd;
  assign cmdStart  = (state == mouseDefs::issue) && !linkBusy && !stepIsRead;
  // Stream reads go back to back, never after a failure
  assign readStart = ((state == mouseDefs::issue) && !linkBusy && stepIsRead) ||
                     ((state == mouseDefs::stream) && !linkBusy && !linkFail);

  assign streaming   = (state == mouseDefs::stream);
  assign streamValid = streaming && linkDone;
  assign streamByte  = rxByte;

  strobeExcl: assert property (@(posedge CLK) disable iff (RESET)
    !(cmdStart && readStart))
    else $error("cmdStart and readStart high together");

endmodule

`default_nettype wire

// File: src/packetAssembler.sv
`timescale 1ns/1ps
`default_nettype none

// Builds movement packets from the streamed bytes
module packetAssembler (
  input  wire logic           CLK,
  input  wire logic           RESET,
  input  wire logic           streaming,
  input  wire logic           streamValid,
  input  wire logic           wheelMode,
  input  wire mouseDefs::byte_t streamByte,
  output mouseDefs::byte_t      MOUSE_STATUS,
  output mouseDefs::byte_t      MOUSE_DX,
  output mouseDefs::byte_t      MOUSE_DY,
  output mouseDefs::byte_t      MOUSE_DZ,
  output logic                SEND_INTERRUPT
);

  // Position of the next byte inside the packet
  logic [1:0] bytePos;
  logic       lastByte;

  // Wheel packets carry a fourth DZ byte
  assign lastByte = wheelMode ? (bytePos == 2'd3) : (bytePos == 2'd2);

  ////////////////////////////////////////////////////////////
  // Byte steering
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      bytePos        <= '0;
      SEND_INTERRUPT <= 1'b0;
      MOUSE_STATUS   <= '0;
      MOUSE_DX       <= '0;
      MOUSE_DY       <= '0;
      MOUSE_DZ       <= '0;
    end else begin
      SEND_INTERRUPT <= 1'b0;
      if (!streaming) begin
        // Partial packet is dropped
        bytePos <= '0;
      end else if (streamValid) begin
        case (bytePos)
          2'd0: MOUSE_STATUS <= streamByte;
          2'd1: MOUSE_DX     <= streamByte;
          2'd2: MOUSE_DY     <= streamByte;
          default: MOUSE_DZ  <= streamByte;
        endcase
        if (lastByte) begin
          bytePos        <= '0;
          SEND_INTERRUPT <= 1'b1;
        end else begin
          bytePos <= bytePos + 1'b1;
        end
      end
    end
  end

  intSingle: assert property (@(posedge CLK) disable iff (RESET)
    SEND_INTERRUPT |=> !SEND_INTERRUPT)
    else $error("SEND_INTERRUPT held for two cycles");

endmodule

`default_nettype wire

// File: src/mouseHost.sv
`timescale 1ns/1ps
`default_nettype none

// PS/2 mouse host, top level
module mouseHost #(
  parameter int POWER_UP_CYCLES = 1_000_000
) (
  input  wire logic              CLK,
  input  wire logic              RESET,
  input  wire logic              BYTE_SENT,
  input  wire logic              BYTE_READY,
  input  wire mouseDefs::byte_t    BYTE_READ,
  input  wire mouseDefs::errCode_t BYTE_ERROR_CODE,
  output logic                   SEND_BYTE,
  output logic                   READ_ENABLE,
  output logic                   SEND_INTERRUPT,
  output logic                   INTELLIMOUSE,
  output mouseDefs::byte_t         BYTE_TO_SEND,
  output mouseDefs::byte_t         MOUSE_STATUS,
  output mouseDefs::byte_t         MOUSE_DX,
  output mouseDefs::byte_t         MOUSE_DY,
  output mouseDefs::byte_t         MOUSE_DZ
);

  ////////////////////////////////////////////////////////////
  // Sequencer to link
  ////////////////////////////////////////////////////////////

  logic             cmdStart;
  logic             readStart;
  logic             linkBusy;
  logic             linkDone;
  logic             linkFail;
  mouseDefs::byte_t cmdByte;
  mouseDefs::byte_t rxByte;

  // Sequencer to packet assembler
  logic             streaming;
  logic             streamValid;
  mouseDefs::byte_t streamByte;

  // Transmitter and receiver handshakes
  hostLink u_link (
    .CLK             (CLK),
    .RESET           (RESET),
    .cmdStart        (cmdStart),
    .readStart       (readStart),
    .BYTE_SENT       (BYTE_SENT),
    .BYTE_READY      (BYTE_READY),
    .cmdByte         (cmdByte),
    .BYTE_READ       (BYTE_READ),
    .BYTE_ERROR_CODE (BYTE_ERROR_CODE),
    .SEND_BYTE       (SEND_BYTE),
    .READ_ENABLE     (READ_ENABLE),
    .linkBusy        (linkBusy),
    .linkDone        (linkDone),
    .linkFail        (linkFail),
    .BYTE_TO_SEND    (BYTE_TO_SEND),
    .rxByte          (rxByte)
  );

  // Init script and stream reads
  mouseSequencer #(
    .POWER_UP_CYCLES (POWER_UP_CYCLES)
  ) u_seq (
    .CLK         (CLK),
    .RESET       (RESET),
    .linkBusy    (linkBusy),
    .linkDone    (linkDone),
    .linkFail    (linkFail),
    .rxByte      (rxByte),
    .cmdStart    (cmdStart),
    .readStart   (readStart),
    .streaming   (streaming),
    .streamValid (streamValid),
    .wheelMode   (INTELLIMOUSE),
    .cmdByte     (cmdByte),
    .streamByte  (streamByte)
  );

  // Packet registers and interrupt
  packetAssembler u_pkt (
    .CLK            (CLK),
    .RESET          (RESET),
    .streaming      (streaming),
    .streamValid    (streamValid),
    .wheelMode      (INTELLIMOUSE),
    .streamByte     (streamByte),
    .MOUSE_STATUS   (MOUSE_STATUS),
    .MOUSE_DX       (MOUSE_DX),
    .MOUSE_DY       (MOUSE_DY),
    .MOUSE_DZ       (MOUSE_DZ),
    .SEND_INTERRUPT (SEND_INTERRUPT)
  );

endmodule

`default_nettype wire

// File: testbench/ps2DeviceModel.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral PS/2 mouse seen through the host's byte ports
module ps2DeviceModel (
  input  wire logic               CLK,
  input  wire logic               RESET,
  input  wire logic               SEND_BYTE,
  input  wire mouseDefs::byte_t   BYTE_TO_SEND,
  input  wire logic               READ_ENABLE,
  input  wire mouseDefs::byte_t   idReply,
  input  wire logic               badSelfTest,
  input  wire logic               midPacketError,
  input  wire logic [2:0]         faultPacket,
  input  wire logic [255:0]       pktTable,
  input  wire logic [63:0]        delayTable,
  output logic                    BYTE_SENT,
  output logic                    BYTE_READY,
  output mouseDefs::byte_t        BYTE_READ,
  output mouseDefs::errCode_t     BYTE_ERROR_CODE
);

  logic       sentQ      = 1'b0;
  logic       readyQ     = 1'b0;
  logic [7:0] dataQ      = 8'h00;
  logic [1:0] errQ       = 2'b00;
  logic       txBusy     = 1'b0;
  logic [3:0] txWait     = 4'd0;
  logic [3:0] rxWait     = 4'd0;
  logic [3:0] dlyIdx     = 4'd0;
  logic [1:0] replyIdx   = 2'd0;
  logic [1:0] replyCount = 2'd0;
  logic       streamOn   = 1'b0;
  logic       faultDone  = 1'b0;
  logic [2:0] pktIdx     = 3'd0;
  logic [1:0] pktPos     = 2'd0;
  logic [7:0] replyBuf [0:2];
  logic [1:0] lastPos;
  logic [3:0] nextDelay;

  assign BYTE_SENT       = sentQ;
  assign BYTE_READY      = readyQ;
  assign BYTE_READ       = dataQ;
  assign BYTE_ERROR_CODE = errQ;

  // Wheel mice send a fourth DZ byte
  assign lastPos   = (idReply == 8'h03) ? 2'd3 : 2'd2;
  // Delays come from a table that wraps every 16 draws
  assign nextDelay = delayTable[dlyIdx*4 +: 4];

  ////////////////////////////////////////////////////////////
  // Command, reply and packet behavior
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (RESET) begin
      sentQ      <= 1'b0;
      readyQ     <= 1'b0;
      errQ       <= 2'b00;
      txBusy     <= 1'b0;
      rxWait     <= 4'd0;
      dlyIdx     <= 4'd0;
      replyIdx   <= 2'd0;
      replyCount <= 2'd0;
      streamOn   <= 1'b0;
      faultDone  <= 1'b0;
      pktIdx     <= 3'd0;
      pktPos     <= 2'd0;
    end else begin
      sentQ  <= 1'b0;
      readyQ <= 1'b0;
      errQ   <= 2'b00;
      if (SEND_BYTE) begin
        // Any command flushes replies and stops streaming
        txBusy     <= 1'b1;
        txWait     <= nextDelay;
        dlyIdx     <= dlyIdx + 4'd1;
        replyIdx   <= 2'd0;
        replyCount <= 2'd0;
        streamOn   <= 1'b0;
        // An unfinished packet is abandoned
        if (pktPos != 2'd0) begin
          pktIdx <= pktIdx + 3'd1;
          pktPos <= 2'd0;
        end
      end else if (txBusy) begin
        if (txWait != 4'd0) begin
          txWait <= txWait - 4'd1;
        end else begin
          txBusy      <= 1'b0;
          sentQ       <= 1'b1;
          replyBuf[0] <= 8'hFA;
          replyCount  <= 2'd1;
          case (BYTE_TO_SEND)
            8'hFF: begin
              // Self-test result then ID 00
              replyBuf[1] <= (badSelfTest && !faultDone) ? 8'hFC : 8'hAA;
              replyBuf[2] <= 8'h00;
              replyCount  <= 2'd3;
              if (badSelfTest) begin
                faultDone <= 1'b1;
              end
            end
            8'hF2: begin
              // Packets follow once the ID is out
              replyBuf[1] <= idReply;
              replyCount  <= 2'd2;
              streamOn    <= 1'b1;
            end
            default: replyCount <= 2'd1;
          endcase
        end
      end else if (READ_ENABLE && !readyQ) begin
        if (rxWait != 4'd0) begin
          rxWait <= rxWait - 4'd1;
        end else if (replyIdx != replyCount) begin
          readyQ   <= 1'b1;
          dataQ    <= replyBuf[replyIdx];
          replyIdx <= replyIdx + 2'd1;
          rxWait   <= nextDelay;
          dlyIdx   <= dlyIdx + 4'd1;
        end else if (streamOn) begin
          readyQ <= 1'b1;
          dataQ  <= pktTable[{pktIdx, pktPos}*8 +: 8];
          rxWait <= nextDelay;
          dlyIdx <= dlyIdx + 4'd1;
          // Receiver error on the DX byte of the chosen packet
          if (midPacketError && !faultDone && (pktIdx == faultPacket) && (pktPos == 2'd1)) begin
            errQ      <= 2'b01;
            faultDone <= 1'b1;
          end
          if (pktPos == lastPos) begin
            pktPos <= 2'd0;
            pktIdx <= pktIdx + 3'd1;
          end else begin
            pktPos <= pktPos + 2'd1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/mouseHostTb.sv
`timescale 1ns/1ps
`default_nettype none

module mouseHostTb;

  localparam int          POWER_UP   = 20;
  localparam int          NUM_ROWS   = 5;
  localparam int          WAIT_LIMIT = 600;
  localparam logic [31:0] LFSR_SEED  = 32'hae8a_b817;

  // Fault kinds in the scenario table
  localparam logic [1:0] FAULT_NONE       = 2'd0;
  localparam logic [1:0] FAULT_SELF_TEST  = 2'd1;
  localparam logic [1:0] FAULT_MID_PACKET = 2'd2;

  logic                CLK   = 1'b0;
  logic                RESET = 1'b1;
  logic                BYTE_SENT;
  logic                BYTE_READY;
  mouseDefs::byte_t    BYTE_READ;
  mouseDefs::errCode_t BYTE_ERROR_CODE;
  logic                SEND_BYTE;
  logic                READ_ENABLE;
  logic                SEND_INTERRUPT;
  logic                INTELLIMOUSE;
  mouseDefs::byte_t    BYTE_TO_SEND;
  mouseDefs::byte_t    MOUSE_STATUS;
  mouseDefs::byte_t    MOUSE_DX;
  mouseDefs::byte_t    MOUSE_DY;
  mouseDefs::byte_t    MOUSE_DZ;

  // Mouse model setup for the current row
  mouseDefs::byte_t idReply        = 8'h00;
  logic             badSelfTest    = 1'b0;
  logic             midPacketError = 1'b0;
  logic [2:0]       faultPacket    = 3'd0;
  logic [255:0]     pktTable       = '0;
  logic [63:0]      delayTable     = '0;
  logic [31:0]      lfsr           = LFSR_SEED;

  // Scenario table: ID reply, fault, packet count, expected INTELLIMOUSE
  mouseDefs::byte_t rowId      [0:NUM_ROWS-1];
  logic [1:0]       rowFault   [0:NUM_ROWS-1];
  int               rowPackets [0:NUM_ROWS-1];
  logic             rowWheel   [0:NUM_ROWS-1];
  mouseDefs::byte_t initCmds   [0:8];

  always #4 CLK = ~CLK;

  mouseHost #(
    .POWER_UP_CYCLES (POWER_UP)
  ) u_dut (
    .CLK             (CLK),
    .RESET           (RESET),
    .BYTE_SENT       (BYTE_SENT),
    .BYTE_READY      (BYTE_READY),
    .BYTE_READ       (BYTE_READ),
    .BYTE_ERROR_CODE (BYTE_ERROR_CODE),
    .SEND_BYTE       (SEND_BYTE),
    .READ_ENABLE     (READ_ENABLE),
    .SEND_INTERRUPT  (SEND_INTERRUPT),
    .INTELLIMOUSE    (INTELLIMOUSE),
    .BYTE_TO_SEND    (BYTE_TO_SEND),
    .MOUSE_STATUS    (MOUSE_STATUS),
    .MOUSE_DX        (MOUSE_DX),
    .MOUSE_DY        (MOUSE_DY),
    .MOUSE_DZ        (MOUSE_DZ)
  );

  ps2DeviceModel u_model (
    .CLK             (CLK),
    .RESET           (RESET),
    .SEND_BYTE       (SEND_BYTE),
    .BYTE_TO_SEND    (BYTE_TO_SEND),
    .READ_ENABLE     (READ_ENABLE),
    .idReply         (idReply),
    .badSelfTest     (badSelfTest),
    .midPacketError  (midPacketError),
    .faultPacket     (faultPacket),
    .pktTable        (pktTable),
    .delayTable      (delayTable),
    .BYTE_SENT       (BYTE_SENT),
    .BYTE_READY      (BYTE_READY),
    .BYTE_READ       (BYTE_READ),
    .BYTE_ERROR_CODE (BYTE_ERROR_CODE)
  );

  ////////////////////////////////////////////////////////////
  // Random source and error reporting
  ////////////////////////////////////////////////////////////

  // Galois form, taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One step per bit taken
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
    return bits;
  endfunction

  task automatic stopWithFail();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    stopWithFail();
  endtask

  task automatic reportFailure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stopWithFail();
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus and response tasks
  ////////////////////////////////////////////////////////////

  // Two reset cycles, new packets and delays for the row
  task automatic applyReset(input int row);
    logic [255:0] packets;
    logic [63:0]  delays;
    for (int i = 0; i < 32; i++) begin
      packets[i*8 +: 8] = 8'(drawBits(8));
    end
    for (int i = 0; i < 16; i++) begin
      delays[i*4 +: 4] = 4'(drawBits(4));
    end
    @(posedge CLK);
    RESET          <= 1'b1;
    idReply        <= rowId[row];
    badSelfTest    <= (rowFault[row] == FAULT_SELF_TEST);
    midPacketError <= (rowFault[row] == FAULT_MID_PACKET);
    faultPacket    <= 3'(rowPackets[row]);
    pktTable       <= packets;
    delayTable     <= delays;
    @(posedge CLK);
    @(negedge CLK);
    assert (!SEND_BYTE && !READ_ENABLE && !SEND_INTERRUPT)
      else reportMismatch("strobe output high during reset");
    assert (!INTELLIMOUSE && (MOUSE_STATUS == 8'h00) && (MOUSE_DX == 8'h00) &&
            (MOUSE_DY == 8'h00) && (MOUSE_DZ == 8'h00))
      else reportMismatch("mouse outputs not cleared by reset");
    @(posedge CLK);
    RESET <= 1'b0;
  endtask

  // Counts rising edges from the reset release
  task automatic checkFirstSend();
    int cycles;
    cycles = 0;
    do begin
      @(posedge CLK);
      cycles++;
      @(negedge CLK);
    end while (!SEND_BYTE && (cycles < WAIT_LIMIT));
    assert (SEND_BYTE) else reportFailure("no SEND_BYTE after reset release");
    assert (cycles == POWER_UP + 2)
      else reportMismatch($sformatf("first SEND_BYTE after %0d cycles, expected %0d",
                                    cycles, POWER_UP + 2));
    assert (BYTE_TO_SEND == 8'hFF)
      else reportMismatch($sformatf("first command %h, expected ff", BYTE_TO_SEND));
  endtask

  // No interrupt may appear while the host is initialising
  task automatic expectCommand(input mouseDefs::byte_t expected, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      assert (!SEND_INTERRUPT)
        else reportMismatch($sformatf("interrupt while waiting for %s", what));
    end while (!SEND_BYTE && (cycles < WAIT_LIMIT));
    assert (SEND_BYTE) else reportFailure($sformatf("no SEND_BYTE for %s", what));
    assert (BYTE_TO_SEND == expected)
      else reportMismatch($sformatf("%s is %h, expected %h", what, BYTE_TO_SEND, expected));
  endtask

  // Everything after the reset command, through the ID request
  task automatic expectInitTail();
    for (int i = 1; i < 9; i++) begin
      expectCommand(initCmds[i], $sformatf("init command %0d", i));
    end
  endtask

  task automatic expectPacket(input int pkt, input logic wheel);
    int               cycles;
    mouseDefs::byte_t expStatus;
    mouseDefs::byte_t expDx;
    mouseDefs::byte_t expDy;
    mouseDefs::byte_t expDz;
    cycles    = 0;
    expStatus = pktTable[pkt*32 +: 8];
    expDx     = pktTable[pkt*32 + 8 +: 8];
    expDy     = pktTable[pkt*32 + 16 +: 8];
    // DZ is never written by a standard mouse
    expDz     = wheel ? pktTable[pkt*32 + 24 +: 8] : 8'h00;
    do begin
      @(negedge CLK);
      cycles++;
    end while (!SEND_INTERRUPT && (cycles < WAIT_LIMIT));
    assert (SEND_INTERRUPT) else reportFailure($sformatf("no interrupt for packet %0d", pkt));
    assert (INTELLIMOUSE == wheel)
      else reportMismatch($sformatf("INTELLIMOUSE is %b, expected %b", INTELLIMOUSE, wheel));
    assert ((MOUSE_STATUS == expStatus) && (MOUSE_DX == expDx) &&
            (MOUSE_DY == expDy) && (MOUSE_DZ == expDz))
      else reportMismatch($sformatf("packet %0d is %h %h %h %h, expected %h %h %h %h", pkt,
                                    MOUSE_STATUS, MOUSE_DX, MOUSE_DY, MOUSE_DZ,
                                    expStatus, expDx, expDy, expDz));
  endtask

  ////////////////////////////////////////////////////////////
  // Scenario loop
  ////////////////////////////////////////////////////////////

  initial begin
    // One column per field, rows 0 to 4 left to right
    rowId      = '{8'h03, 8'h00, 8'h03, 8'h00, 8'h03};
    rowFault   = '{FAULT_NONE, FAULT_NONE, FAULT_SELF_TEST, FAULT_MID_PACKET, FAULT_MID_PACKET};
    rowPackets = '{4, 3, 2, 2, 3};
    rowWheel   = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    // Reset, enable, knock 200 100 80, get ID
    initCmds = '{8'hFF, 8'hF4, 8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF2};

    for (int row = 0; row < NUM_ROWS; row++) begin
      applyReset(row);
      checkFirstSend();
      if (rowFault[row] == FAULT_SELF_TEST) begin
        expectCommand(8'hFF, "reset retry after bad self-test");
      end
      expectInitTail();
      for (int p = 0; p < rowPackets[row]; p++) begin
        expectPacket(p, rowWheel[row]);
      end
      // Faulted packet is dropped and streaming resumes with the next one
      if (rowFault[row] == FAULT_MID_PACKET) begin
        expectCommand(8'hFF, "reset after packet error");
        expectInitTail();
        expectPacket(rowPackets[row] + 1, rowWheel[row]);
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
src/mouseDefs.sv
src/hostLink.sv
src/mouseSequencer.sv
src/packetAssembler.sv
src/mouseHost.sv
testbench/ps2DeviceModel.sv
testbench/mouseHostTb.sv
